//--- hdl/cam_pkg.sv
`default_nettype none

package cam_pkg;

    // ----------------------------------------
    // camera pixel widths
    // ----------------------------------------
    localparam int RAW_BITS  = 10;
    localparam int GRAY_BITS = 8;

    // ----------------------------------------
    // capture window
    // ----------------------------------------
    // 16x16 window addressed as y then x
    localparam int WIN_BITS      = 4;
    localparam int BUF_ADDR_BITS = 2 * WIN_BITS;

    // wide enough for a full sensor line
    localparam int CAM_COORD_BITS = 14;

    typedef logic [CAM_COORD_BITS-1:0] cam_coord_t;
    typedef logic [RAW_BITS-1:0]       raw_pix_t;
    typedef logic [GRAY_BITS-1:0]      gray_pix_t;
    typedef logic [BUF_ADDR_BITS-1:0]  buf_addr_t;

endpackage

`default_nettype wire

//--- hdl/cam_window_writer.sv
`default_nettype none

module cam_window_writer
    import cam_pkg::*;
(
    input  var logic      cam_clk,
    input  var logic      sys_reset,

    input  var logic      fv_i,
    input  var logic      lv_i,
    input  var raw_pix_t  pixel_i,

    output var logic      wr_en_o,
    output var buf_addr_t wr_addr_o,
    output var gray_pix_t wr_data_o
);

    // ----------------------------------------
    // input register stage
    // ----------------------------------------
    logic     fv_ff;
    logic     lv_ff;
    logic     lv_prev;
    raw_pix_t pix_ff;

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            fv_ff <= 1'b0;
            lv_ff <= 1'b0;
        end else begin
            fv_ff <= fv_i;
            lv_ff <= lv_i;
        end
    end

    always_ff @(posedge cam_clk) begin
        pix_ff <= pixel_i;
    end

    // ----------------------------------------
    // coordinate counters
    // ----------------------------------------
    cam_coord_t x_cnt;
    cam_coord_t y_cnt;
    logic       take;
    logic       in_window;

    assign take      = fv_ff && lv_ff;
    assign in_window = (x_cnt < cam_coord_t'(2 ** WIN_BITS))
                    && (y_cnt < cam_coord_t'(2 ** WIN_BITS));

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            lv_prev <= 1'b0;
            x_cnt   <= '0;
            y_cnt   <= '0;
        end else begin
            lv_prev <= lv_ff;
            // x restarts with every line
            if (!lv_ff) begin
                x_cnt <= '0;
            end else if (take) begin
                x_cnt <= x_cnt + 1'b1;
            end
            // frame gap wins over a trailing line end
            if (!fv_ff) begin
                y_cnt <= '0;
            end else if (lv_prev && !lv_ff) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // write stage
    // ----------------------------------------
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= take && in_window;
        end
    end

    always_ff @(posedge cam_clk) begin
        wr_addr_o <= {y_cnt[WIN_BITS-1:0], x_cnt[WIN_BITS-1:0]};
        // keep the top bits as gray
        wr_data_o <= pix_ff[RAW_BITS-1 -: GRAY_BITS];
    end

endmodule

`default_nettype wire

//--- hdl/frame_buffer.sv
`default_nettype none

module frame_buffer (
    input  var logic                cam_clk,

    // write port from the capture side
    input  var logic                wr_en_i,
    input  var cam_pkg::buf_addr_t  wr_addr_i,
    input  var cam_pkg::gray_pix_t  wr_data_i,

    // read port from the display side
    input  var cam_pkg::buf_addr_t  rd_addr_i,
    output var cam_pkg::gray_pix_t  rd_data_o
);

    // ----------------------------------------
    // storage
    // ----------------------------------------
    // one entry per window pixel
    cam_pkg::gray_pix_t mem [2 ** cam_pkg::BUF_ADDR_BITS];

    always_ff @(posedge cam_clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // ----------------------------------------
    // registered read
    // ----------------------------------------
    // one cycle from address to data
    always_ff @(posedge cam_clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

//--- hdl/stereo_capture_top.sv
`default_nettype none

module stereo_capture_top
    import cam_pkg::*;
    import video_pkg::*;
(
    input  var logic      cam_clk,
    input  var logic      sys_reset,

    input  var logic      cam0_fv_i,
    input  var logic      cam0_lv_i,
    input  var raw_pix_t  cam0_pixel_i,
    input  var logic      cam1_fv_i,
    input  var logic      cam1_lv_i,
    input  var raw_pix_t  cam1_pixel_i,

    output var logic      de_o,
    output var logic      hsync_o,
    output var logic      vsync_o,
    output var gray_pix_t pix_o
);

    // ----------------------------------------
    // capture side
    // ----------------------------------------
    logic      cam0_wr_en;
    buf_addr_t cam0_wr_addr;
    gray_pix_t cam0_wr_data;
    logic      cam1_wr_en;
    buf_addr_t cam1_wr_addr;
    gray_pix_t cam1_wr_data;

    cam_window_writer u_writer_cam0 (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .fv_i      (cam0_fv_i),
        .lv_i      (cam0_lv_i),
        .pixel_i   (cam0_pixel_i),
        .wr_en_o   (cam0_wr_en),
        .wr_addr_o (cam0_wr_addr),
        .wr_data_o (cam0_wr_data)
    );

    cam_window_writer u_writer_cam1 (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .fv_i      (cam1_fv_i),
        .lv_i      (cam1_lv_i),
        .pixel_i   (cam1_pixel_i),
        .wr_en_o   (cam1_wr_en),
        .wr_addr_o (cam1_wr_addr),
        .wr_data_o (cam1_wr_data)
    );

    // ----------------------------------------
    // frame buffers
    // ----------------------------------------
    buf_addr_t rd_addr;
    gray_pix_t cam0_rd_data;
    gray_pix_t cam1_rd_data;

    frame_buffer u_buf_cam0 (
        .cam_clk   (cam_clk),
        .wr_en_i   (cam0_wr_en),
        .wr_addr_i (cam0_wr_addr),
        .wr_data_i (cam0_wr_data),
        .rd_addr_i (rd_addr),
        .rd_data_o (cam0_rd_data)
    );

    frame_buffer u_buf_cam1 (
        .cam_clk   (cam_clk),
        .wr_en_i   (cam1_wr_en),
        .wr_addr_i (cam1_wr_addr),
        .wr_data_i (cam1_wr_data),
        .rd_addr_i (rd_addr),
        .rd_data_o (cam1_rd_data)
    );

    // ----------------------------------------
    // display side
    // ----------------------------------------
    logic    tg_de;
    logic    tg_hsync;
    logic    tg_vsync;
    disp_h_t tg_x;
    disp_v_t tg_y;

    video_timing_gen u_timing (
        .cam_clk   (cam_clk),
        .sys_reset (sys_reset),
        .de_o      (tg_de),
        .hsync_o   (tg_hsync),
        .vsync_o   (tg_vsync),
        .disp_x_o  (tg_x),
        .disp_y_o  (tg_y)
    );

    stereo_display_mux u_mux (
        .cam_clk     (cam_clk),
        .sys_reset   (sys_reset),
        .de_i        (tg_de),
        .hsync_i     (tg_hsync),
        .vsync_i     (tg_vsync),
        .disp_x_i    (tg_x),
        .disp_y_i    (tg_y),
        .rd_addr_o   (rd_addr),
        .cam0_data_i (cam0_rd_data),
        .cam1_data_i (cam1_rd_data),
        .de_o        (de_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .pix_o       (pix_o)
    );

endmodule

`default_nettype wire

//--- hdl/stereo_display_mux.sv
`default_nettype none

module stereo_display_mux
    import cam_pkg::*;
    import video_pkg::*;
(
    input  var logic      cam_clk,
    input  var logic      sys_reset,

    input  var logic      de_i,
    input  var logic      hsync_i,
    input  var logic      vsync_i,
    input  var disp_h_t   disp_x_i,
    input  var disp_v_t   disp_y_i,

    // shared by both buffers
    output var buf_addr_t rd_addr_o,
    input  var gray_pix_t cam0_data_i,
    input  var gray_pix_t cam1_data_i,

    output var logic      de_o,
    output var logic      hsync_o,
    output var logic      vsync_o,
    output var gray_pix_t pix_o
);

    // window address from the low coordinate bits
    always_ff @(posedge cam_clk) begin
        rd_addr_o <= {disp_y_i[WIN_BITS-1:0], disp_x_i[WIN_BITS-1:0]};
    end

    // ----------------------------------------
    // sync and select delay
    // ----------------------------------------
    logic [READ_LATENCY-1:0] de_dly;
    logic [READ_LATENCY-1:0] hsync_dly;
    logic [READ_LATENCY-1:0] vsync_dly;
    logic [READ_LATENCY-1:0] sel_dly;

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            de_dly    <= '0;
            hsync_dly <= '0;
            vsync_dly <= '0;
            sel_dly   <= '0;
        end else begin
            de_dly    <= {de_dly[READ_LATENCY-2:0], de_i};
            hsync_dly <= {hsync_dly[READ_LATENCY-2:0], hsync_i};
            vsync_dly <= {vsync_dly[READ_LATENCY-2:0], vsync_i};
            // right half of the screen is camera 0
            sel_dly   <= {sel_dly[READ_LATENCY-2:0], disp_x_i[WIN_BITS]};
        end
    end

    assign de_o    = de_dly[READ_LATENCY-1];
    assign hsync_o = hsync_dly[READ_LATENCY-1];
    assign vsync_o = vsync_dly[READ_LATENCY-1];
    assign pix_o   = sel_dly[READ_LATENCY-1] ? cam0_data_i : cam1_data_i;

endmodule

`default_nettype wire

//--- hdl/video_pkg.sv
`default_nettype none

package video_pkg;

    // ----------------------------------------
    // horizontal timing in cycles
    // ----------------------------------------
    localparam int H_ACTIVE     = 32;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_END   = 38;
    localparam int H_TOTAL      = 40;

    // ----------------------------------------
    // vertical timing in lines
    // ----------------------------------------
    localparam int V_ACTIVE     = 16;
    localparam int V_SYNC_START = 17;
    localparam int V_SYNC_END   = 19;
    localparam int V_TOTAL      = 20;

    // coordinate to pixel output
    localparam int READ_LATENCY = 2;

    localparam int H_BITS = $clog2(H_TOTAL);
    localparam int V_BITS = $clog2(V_TOTAL);

    typedef logic [H_BITS-1:0] disp_h_t;
    typedef logic [V_BITS-1:0] disp_v_t;

    typedef enum logic [1:0] {H_ACT, H_FRONT, H_SYNC, H_BACK} h_phase_e;
    typedef enum logic [1:0] {V_ACT, V_FRONT, V_SYNC, V_BACK} v_phase_e;

endpackage

`default_nettype wire

//--- hdl/video_timing_gen.sv
`default_nettype none

module video_timing_gen
    import video_pkg::*;
(
    input  var logic    cam_clk,
    input  var logic    sys_reset,

    output var logic    de_o,
    output var logic    hsync_o,
    output var logic    vsync_o,
    output var disp_h_t disp_x_o,
    output var disp_v_t disp_y_o
);

    // ----------------------------------------
    // horizontal counter and phase
    // ----------------------------------------
    disp_h_t  h_cnt;
    h_phase_e h_phase;
    logic     h_wrap;

    assign h_wrap = (h_cnt == disp_h_t'(H_TOTAL - 1));

    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            h_cnt   <= '0;
            h_phase <= H_ACT;
        end else if (h_wrap) begin
            h_cnt   <= '0;
            h_phase <= H_ACT;
        end else begin
            h_cnt <= h_cnt + 1'b1;
            // phase follows the value the counter moves to
            case (h_cnt + 1'b1)
                disp_h_t'(H_ACTIVE):     h_phase <= H_FRONT;
                disp_h_t'(H_SYNC_START): h_phase <= H_SYNC;
                disp_h_t'(H_SYNC_END):   h_phase <= H_BACK;
                default:                 h_phase <= h_phase;
            endcase
        end
    end

    // ----------------------------------------
    // vertical counter and phase
    // ----------------------------------------
    disp_v_t  v_cnt;
    v_phase_e v_phase;
    logic     v_wrap;

    assign v_wrap = (v_cnt == disp_v_t'(V_TOTAL - 1));

    // advances once per line on the horizontal wrap
    always_ff @(posedge cam_clk or posedge sys_reset) begin
        if (sys_reset) begin
            v_cnt   <= '0;
            v_phase <= V_ACT;
        end else if (h_wrap) begin
            if (v_wrap) begin
                v_cnt   <= '0;
                v_phase <= V_ACT;
            end else begin
                v_cnt <= v_cnt + 1'b1;
                case (v_cnt + 1'b1)
                    disp_v_t'(V_ACTIVE):     v_phase <= V_FRONT;
                    disp_v_t'(V_SYNC_START): v_phase <= V_SYNC;
                    disp_v_t'(V_SYNC_END):   v_phase <= V_BACK;
                    default:                 v_phase <= v_phase;
                endcase
            end
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign de_o     = (h_phase == H_ACT) && (v_phase == V_ACT);
    assign hsync_o  = (h_phase == H_SYNC);
    assign vsync_o  = (v_phase == V_SYNC);
    assign disp_x_o = h_cnt;
    assign disp_y_o = v_cnt;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the stereo capture testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_stereo_capture \
    --Mdir obj_dir -o sim_tb \
    -f src.f

# keep running after an assertion error so the testbench can report it
output=$(./obj_dir/sim_tb +verilator+error+limit+1000)
echo "$output"

if grep -qx "Simulation passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

//--- src.f
hdl/cam_pkg.sv
hdl/video_pkg.sv
hdl/cam_window_writer.sv
hdl/frame_buffer.sv
hdl/video_timing_gen.sv
hdl/stereo_display_mux.sv
hdl/stereo_capture_top.sv
test/stereo_capture_asserts.sv
test/tb_stereo_capture.sv

//--- test/stereo_capture_asserts.sv
`default_nettype none

module stereo_capture_asserts (
    input var logic cam_clk,
    input var logic sys_reset,
    input var logic de_i,
    input var logic hsync_i,
    input var logic vsync_i,
    input var logic cam0_fv_i,
    input var logic cam1_fv_i,
    input var logic cam0_wr_en_i,
    input var logic cam1_wr_en_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // ----------------------------------------
    // display outputs
    // ----------------------------------------
    de_hsync_apart: assert property (@(posedge cam_clk) disable iff (sys_reset)
        !(de_i && hsync_i))
        else begin
            $error("de and hsync high in the same cycle");
            fail_count++;
        end

    de_vsync_apart: assert property (@(posedge cam_clk) disable iff (sys_reset)
        !(de_i && vsync_i))
        else begin
            $error("de and vsync high in the same cycle");
            fail_count++;
        end

    // pulse is exactly four cycles wide
    hsync_width: assert property (@(posedge cam_clk) disable iff (sys_reset)
        $fell(hsync_i) |-> $past(hsync_i, 1) && $past(hsync_i, 2) && $past(hsync_i, 3)
                           && $past(hsync_i, 4) && !$past(hsync_i, 5))
        else begin
            $error("hsync pulse is not four cycles wide");
            fail_count++;
        end

    // ----------------------------------------
    // write enables follow frame valid
    // ----------------------------------------
    cam0_wr_in_frame: assert property (@(posedge cam_clk) disable iff (sys_reset)
        cam0_wr_en_i |-> $past(cam0_fv_i, 2))
        else begin
            $error("camera 0 write without frame valid");
            fail_count++;
        end

    cam1_wr_in_frame: assert property (@(posedge cam_clk) disable iff (sys_reset)
        cam1_wr_en_i |-> $past(cam1_fv_i, 2))
        else begin
            $error("camera 1 write without frame valid");
            fail_count++;
        end

endmodule

bind stereo_capture_top stereo_capture_asserts i_asserts (
    .cam_clk      (cam_clk),
    .sys_reset    (sys_reset),
    .de_i         (de_o),
    .hsync_i      (hsync_o),
    .vsync_i      (vsync_o),
    .cam0_fv_i    (cam0_fv_i),
    .cam1_fv_i    (cam1_fv_i),
    .cam0_wr_en_i (cam0_wr_en),
    .cam1_wr_en_i (cam1_wr_en)
);

`default_nettype wire

//--- test/tb_stereo_capture.sv
`default_nettype none

module tb_stereo_capture
    import cam_pkg::*;
    import video_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 16;
    localparam int ROUNDS         = 6;
    localparam int WIN_SIZE       = 2 ** WIN_BITS;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int WAVE_MAX       = 640;
    localparam int TIMEOUT_CYCLES = ROUNDS * (2 * FRAME_CYCLES + 600) + 2000;

    logic      cam_clk;
    logic      sys_reset;
    logic      cam0_fv_i;
    logic      cam0_lv_i;
    raw_pix_t  cam0_pixel_i;
    logic      cam1_fv_i;
    logic      cam1_lv_i;
    raw_pix_t  cam1_pixel_i;
    logic      de_o;
    logic      hsync_o;
    logic      vsync_o;
    gray_pix_t pix_o;

    // per camera {fv, lv, pixel} for every cycle of the next frame
    logic [11:0] wave [0:1][0:WAVE_MAX-1];
    int          wave_len [0:1];
    gray_pix_t   model_mem [0:1][0:255];
    logic [31:0] lfsr_state = 32'ha668;
    int          check_count = 0;
    int          error_count = 0;

    stereo_capture_top i_dut (
        .cam_clk      (cam_clk),
        .sys_reset    (sys_reset),
        .cam0_fv_i    (cam0_fv_i),
        .cam0_lv_i    (cam0_lv_i),
        .cam0_pixel_i (cam0_pixel_i),
        .cam1_fv_i    (cam1_fv_i),
        .cam1_lv_i    (cam1_lv_i),
        .cam1_pixel_i (cam1_pixel_i),
        .de_o         (de_o),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .pix_o        (pix_o)
    );

    initial begin
        cam_clk = 1'b0;
        forever #5 cam_clk = ~cam_clk;
    end

    // ----------------------------------------
    // random source and compare
    // ----------------------------------------
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH t=%0t %s expected=%0h actual=%0h", $time, name, expected,
                     actual);
        end
    endtask

    // ----------------------------------------
    // camera stimulus
    // ----------------------------------------
    task automatic push_sample(input int cam, input logic fv, input logic lv,
                               input raw_pix_t pix);
        wave[cam][wave_len[cam]] = {fv, lv, pix};
        wave_len[cam] = wave_len[cam] + 1;
    endtask

    // builds one frame and updates the model with what lands in the window
    task automatic build_frame(input int cam, input int width, input int height,
                               input int gap);
        raw_pix_t pix;
        wave_len[cam] = 0;
        // fv low first so the row count restarts at 0
        push_sample(cam, 1'b0, 1'b0, '0);
        push_sample(cam, 1'b1, 1'b0, '0);
        for (int r = 0; r < height; r++) begin
            for (int c = 0; c < width; c++) begin
                pix = raw_pix_t'(rand_bits(RAW_BITS));
                push_sample(cam, 1'b1, 1'b1, pix);
                if (r < WIN_SIZE && c < WIN_SIZE) begin
                    model_mem[cam][r * WIN_SIZE + c] = gray_pix_t'(pix / 4);
                end
            end
            for (int g = 0; g < gap; g++) begin
                push_sample(cam, 1'b1, 1'b0, '0);
            end
        end
        push_sample(cam, 1'b0, 1'b0, '0);
    endtask

    task automatic play_frames();
        int n;
        n = (wave_len[0] > wave_len[1]) ? wave_len[0] : wave_len[1];
        for (int i = 0; i < n; i++) begin
            @(posedge cam_clk);
            if (i < wave_len[0]) begin
                {cam0_fv_i, cam0_lv_i, cam0_pixel_i} <= wave[0][i];
            end else begin
                {cam0_fv_i, cam0_lv_i, cam0_pixel_i} <= '0;
            end
            if (i < wave_len[1]) begin
                {cam1_fv_i, cam1_lv_i, cam1_pixel_i} <= wave[1][i];
            end else begin
                {cam1_fv_i, cam1_lv_i, cam1_pixel_i} <= '0;
            end
        end
        @(posedge cam_clk);
        {cam0_fv_i, cam0_lv_i, cam0_pixel_i} <= '0;
        {cam1_fv_i, cam1_lv_i, cam1_pixel_i} <= '0;
    endtask

    // ----------------------------------------
    // display frame check
    // ----------------------------------------
    // starts at a vsync_o rise at line 17 column 0 of the display
    task automatic verify_frame();
        int        t;
        int        h;
        int        v;
        int        col;
        int        row;
        int        first_de;
        int        vs_high;
        logic      prev_vs;
        logic      prev_de;
        logic      prev_hs;
        logic      de_pending;
        gray_pix_t exp_pix;
        prev_vs = 1'b1;
        @(negedge cam_clk);
        while (!(vsync_o && !prev_vs)) begin
            prev_vs = vsync_o;
            @(negedge cam_clk);
        end
        col        = 0;
        row        = 0;
        first_de   = 0;
        vs_high    = 1;
        prev_vs    = 1'b1;
        prev_de    = 1'b0;
        prev_hs    = 1'b0;
        de_pending = 1'b0;
        for (int i = 1; i <= FRAME_CYCLES; i++) begin
            @(negedge cam_clk);
            t = (V_SYNC_START * H_TOTAL + i) % FRAME_CYCLES;
            h = t % H_TOTAL;
            v = t / H_TOTAL;
            compare_value("de_o", 32'(h < H_ACTIVE && v < V_ACTIVE), 32'(de_o));
            compare_value("hsync_o", 32'(h >= H_SYNC_START && h < H_SYNC_END), 32'(hsync_o));
            compare_value("vsync_o", 32'(v >= V_SYNC_START && v < V_SYNC_END), 32'(vsync_o));
            if (de_o) begin
                if (!prev_de) begin
                    first_de   = i;
                    de_pending = 1'b1;
                end
                if (row < V_ACTIVE && col < H_ACTIVE) begin
                    // right half is camera 0 and left half camera 1
                    if (col >= WIN_SIZE) begin
                        exp_pix = model_mem[0][row * WIN_SIZE + col - WIN_SIZE];
                    end else begin
                        exp_pix = model_mem[1][row * WIN_SIZE + col];
                    end
                    compare_value("pix_o", 32'(exp_pix), 32'(pix_o));
                end
                col++;
            end else if (prev_de) begin
                compare_value("de_per_line", H_ACTIVE, col);
                col = 0;
                row++;
            end
            if (hsync_o && !prev_hs && de_pending) begin
                compare_value("hsync_offset", H_SYNC_START, i - first_de);
                de_pending = 1'b0;
            end
            if (vsync_o && i < FRAME_CYCLES) begin
                vs_high++;
            end
            if (i == FRAME_CYCLES) begin
                compare_value("vsync_period", 32'd1, 32'(vsync_o && !prev_vs));
            end
            prev_de = de_o;
            prev_hs = hsync_o;
            prev_vs = vsync_o;
        end
        compare_value("de_lines", V_ACTIVE, row);
        compare_value("vsync_width", (V_SYNC_END - V_SYNC_START) * H_TOTAL, vs_high);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main
        int width;
        int height;
        int gap;
        int assert_fails;
        logic send;
        sys_reset    <= 1'b1;
        cam0_fv_i    <= 1'b0;
        cam0_lv_i    <= 1'b0;
        cam0_pixel_i <= '0;
        cam1_fv_i    <= 1'b0;
        cam1_lv_i    <= 1'b0;
        cam1_pixel_i <= '0;
        repeat (RESET_CYCLES - 1) @(posedge cam_clk);
        @(negedge cam_clk);
        compare_value("reset de_o", 32'd0, 32'(de_o));
        compare_value("reset hsync_o", 32'd0, 32'(hsync_o));
        compare_value("reset vsync_o", 32'd0, 32'(vsync_o));
        @(posedge cam_clk);
        sys_reset <= 1'b0;
        @(negedge cam_clk);
        compare_value("reset de_o", 32'd0, 32'(de_o));
        compare_value("reset hsync_o", 32'd0, 32'(hsync_o));
        compare_value("reset vsync_o", 32'd0, 32'(vsync_o));

        // rounds 4 and 5 restart one camera only
        for (int round = 0; round < ROUNDS; round++) begin
            for (int cam = 0; cam < 2; cam++) begin
                wave_len[cam] = 0;
                send = (round < 4) || (round == 4 && cam == 0) || (round == 5 && cam == 1);
                if (send) begin
                    width  = 10 + int'(rand_bits(4) % 15);
                    height = 10 + int'(rand_bits(4) % 11);
                    gap    = 2 + int'(rand_bits(3) % 5);
                    // first frame covers the whole window
                    if (round == 0) begin
                        width  = 24;
                        height = 20;
                    end
                    build_frame(cam, width, height, gap);
                end
            end
            play_frames();
            verify_frame();
        end

        assert_fails = i_dut.i_asserts.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge cam_clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
